/* umode_pkg.sv */
// Shared types, encodings and rule positions for the U/M privilege monitor, used by scoped name
`default_nettype none

package umode_pkg;

  // Vectors that carry a meaning of their own
  typedef logic [1:0]  priv_mode_t;
  typedef logic [31:0] insn_t;
  typedef logic [31:0] csr_word_t;
  typedef logic [5:0]  exc_cause_t;
  typedef logic [15:0] seq_t;
  typedef logic [11:0] rule_mask_t;

  // Privilege-relevant instruction classes
  typedef enum logic [2:0] {
    insn_other,
    insn_mret,
    insn_wfi,
    insn_uret,
    insn_custom,
    insn_csr
  } insn_class_e;

  // Bit positions inside rule_mask_t
  typedef enum int unsigned {
    rule_misa      = 0,
    rule_mode      = 1,
    rule_mpp       = 2,
    rule_spp       = 3,
    rule_ext       = 4,
    rule_mscratch  = 5,
    rule_illegal   = 6,
    rule_trap_mode = 7,
    rule_dbg_mode  = 8,
    rule_dret_prv  = 9,
    rule_dbg_entry = 10,
    rule_init_mode = 11
  } rule_idx_e;

  localparam priv_mode_t MODE_U = 2'b00;
  localparam priv_mode_t MODE_M = 2'b11;

  // Fetch faults revoke the retired instruction
  localparam exc_cause_t CAUSE_INSTR_FAULT     = 6'd1;
  localparam exc_cause_t CAUSE_ILLEGAL_INSN    = 6'd2;
  localparam exc_cause_t CAUSE_INSTR_BUS_FAULT = 6'd24;

  localparam int MISA_U_POS = 20;
  localparam int MISA_S_POS = 18;
  localparam int MISA_N_POS = 13;

  // mstatus fields, MPP, FS and XS are two bits wide
  localparam int MPP_POS = 11;
  localparam int SPP_POS = 8;
  localparam int FS_POS  = 13;
  localparam int XS_POS  = 15;
  localparam int SD_POS  = 31;
  localparam int TW_POS  = 21;

  localparam int PRV_POS = 0;

  localparam insn_t MRET_IDATA    = 32'b0011000_00010_00000_000_00000_1110011;
  localparam insn_t WFI_IDATA     = 32'b0001000_00101_00000_000_00000_1110011;
  localparam insn_t URET_IDATA    = 32'b0000000_00010_00000_000_00000_1110011;
  localparam insn_t CUSTOM0_IDATA = 32'b100011_00000000000_000_00000_1110011;
  localparam insn_t CUSTOM1_IDATA = 32'b110011_00000000000_000_00000_1110011;
  localparam insn_t CUSTOM_IMASK  = 32'b111111_00000000000_111_00000_1111111;

  localparam logic [6:0] SYSTEM_OPCODE = 7'b1110011;

endpackage

`default_nettype wire

/* retire_skid.sv */
// Input stage of the monitor, a two-entry skid buffer between the retire port and the checker
`timescale 1ns/1ps
`default_nettype none

module retire_skid (
  input  wire                        clk_i,
  input  wire                        rst_ni,
  input  wire                        rec_valid,
  output logic                       rec_ready,
  input  wire  umode_pkg::priv_mode_t rec_mode,
  input  wire  umode_pkg::insn_t      rec_insn,
  input  wire                        rec_trap,
  input  wire  umode_pkg::exc_cause_t rec_cause,
  input  wire                        rec_dbg_mode,
  input  wire  umode_pkg::csr_word_t  rec_mstatus,
  input  wire  umode_pkg::csr_word_t  rec_misa,
  input  wire  umode_pkg::csr_word_t  rec_dcsr,
  input  wire  umode_pkg::csr_word_t  rec_mscratch_wmask,
  output logic                       chk_valid,
  input  wire                        chk_ready,
  output umode_pkg::priv_mode_t      chk_mode,
  output umode_pkg::insn_t           chk_insn,
  output logic                       chk_trap,
  output umode_pkg::exc_cause_t      chk_cause,
  output logic                       chk_dbg_mode,
  output umode_pkg::csr_word_t       chk_mstatus,
  output umode_pkg::csr_word_t       chk_misa,
  output umode_pkg::csr_word_t       chk_dcsr,
  output umode_pkg::csr_word_t       chk_mscratch_wmask
);

  localparam int REC_W = $bits(umode_pkg::priv_mode_t) + $bits(umode_pkg::insn_t) + 2 +
                         $bits(umode_pkg::exc_cause_t) + 4 * $bits(umode_pkg::csr_word_t);

  logic [REC_W-1:0] rec_in;
  logic [REC_W-1:0] main_q;
  logic [REC_W-1:0] skid_q;
  logic             skid_valid_q;
  logic             in_fire;
  logic             main_load;

  // Whole record travels as one flat word inside the buffer
  assign rec_in = {rec_mode, rec_insn, rec_trap, rec_cause, rec_dbg_mode,
                   rec_mstatus, rec_misa, rec_dcsr, rec_mscratch_wmask};
  assign {chk_mode, chk_insn, chk_trap, chk_cause, chk_dbg_mode,
          chk_mstatus, chk_misa, chk_dcsr, chk_mscratch_wmask} = main_q;

  // Ready comes straight from the skid flop, never from chk_ready
  assign rec_ready = !skid_valid_q;
  assign in_fire   = rec_valid && rec_ready;
  assign main_load = !chk_valid || chk_ready;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      chk_valid    <= 1'b0;
      skid_valid_q <= 1'b0;
    end else if (main_load) begin
      // Skid entry drains first so order is kept
      chk_valid    <= skid_valid_q || in_fire;
      skid_valid_q <= 1'b0;
    end else if (in_fire) begin
      skid_valid_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (main_load) begin
      main_q <= skid_valid_q ? skid_q : rec_in;
    end else if (in_fire) begin
      skid_q <= rec_in;
    end
  end

endmodule

`default_nettype wire

/* insn_classifier.sv */
// Sorts a retired instruction word into the classes the privilege rules care about
`timescale 1ns/1ps
`default_nettype none

module insn_classifier (
  input  wire  umode_pkg::insn_t      insn,
  input  wire                        trap,
  input  wire  umode_pkg::exc_cause_t cause,
  output umode_pkg::insn_class_e     insn_class
);

  logic       revoked;
  logic       is_system;
  logic [2:0] funct3;

  // A fetch fault means the word was never really executed
  assign revoked = trap && ((cause == umode_pkg::CAUSE_INSTR_FAULT) ||
                            (cause == umode_pkg::CAUSE_INSTR_BUS_FAULT));

  assign is_system = (insn[6:0] == umode_pkg::SYSTEM_OPCODE);
  assign funct3    = insn[14:12];

  always_comb begin
    insn_class = umode_pkg::insn_other;
    if (!revoked) begin
      if (insn == umode_pkg::MRET_IDATA) begin
        insn_class = umode_pkg::insn_mret;
      end else if (insn == umode_pkg::WFI_IDATA) begin
        insn_class = umode_pkg::insn_wfi;
      end else if (insn == umode_pkg::URET_IDATA) begin
        insn_class = umode_pkg::insn_uret;
      end else if (((insn & umode_pkg::CUSTOM_IMASK) == umode_pkg::CUSTOM0_IDATA) ||
                   ((insn & umode_pkg::CUSTOM_IMASK) == umode_pkg::CUSTOM1_IDATA)) begin
        insn_class = umode_pkg::insn_custom;
      end else if (is_system && (funct3 != 3'd0) && (funct3 != 3'd4)) begin
        // CSR access, register or immediate form
        insn_class = umode_pkg::insn_csr;
      end
    end
  end

endmodule

`default_nettype wire

/* priv_rule_checker.sv */
// Rule engine of the monitor, checks one record against the U/M rules and registers the mask
`timescale 1ns/1ps
`default_nettype none

module priv_rule_checker (
  input  wire                        clk_i,
  input  wire                        rst_ni,
  input  wire                        chk_valid,
  output logic                       chk_ready,
  input  wire  umode_pkg::priv_mode_t chk_mode,
  input  wire  umode_pkg::insn_t      chk_insn,
  input  wire                        chk_trap,
  input  wire  umode_pkg::exc_cause_t chk_cause,
  input  wire                        chk_dbg_mode,
  input  wire  umode_pkg::csr_word_t  chk_mstatus,
  input  wire  umode_pkg::csr_word_t  chk_misa,
  input  wire  umode_pkg::csr_word_t  chk_dcsr,
  input  wire  umode_pkg::csr_word_t  chk_mscratch_wmask,
  output logic                       push_valid,
  input  wire                        push_ready,
  output umode_pkg::seq_t            push_seq,
  output umode_pkg::rule_mask_t      push_rules
);

  umode_pkg::insn_class_e insn_class;
  umode_pkg::rule_mask_t  rules;
  umode_pkg::seq_t        seq_q;
  umode_pkg::priv_mode_t  mpp;
  umode_pkg::priv_mode_t  cur_prv;
  umode_pkg::priv_mode_t  prev_mode_q;
  umode_pkg::priv_mode_t  prev_prv_q;
  logic                   seen_q;
  logic                   prev_trap_q;
  logic                   prev_dbg_q;
  logic                   chk_fire;
  logic                   push_fire;
  logic                   in_umode;
  logic                   traps_illegal;
  logic                   illegal_hit;

  insn_classifier i_classifier (
    .insn       (chk_insn),
    .trap       (chk_trap),
    .cause      (chk_cause),
    .insn_class (insn_class)
  );

  // Stall only while a violation waits for the FIFO
  assign chk_ready = !push_valid || push_ready;
  assign chk_fire  = chk_valid && chk_ready;
  assign push_fire = push_valid && push_ready;

  assign in_umode      = (chk_mode == umode_pkg::MODE_U);
  assign traps_illegal = chk_trap && (chk_cause == umode_pkg::CAUSE_ILLEGAL_INSN);
  assign mpp           = chk_mstatus[umode_pkg::MPP_POS +: 2];
  assign cur_prv       = chk_dcsr[umode_pkg::PRV_POS +: 2];

  // Instructions that should have trapped as illegal
  always_comb begin
    illegal_hit = 1'b0;
    case (insn_class)
      umode_pkg::insn_uret,
      umode_pkg::insn_custom: illegal_hit = 1'b1;
      umode_pkg::insn_mret:   illegal_hit = in_umode;
      umode_pkg::insn_wfi:    illegal_hit = in_umode && chk_mstatus[umode_pkg::TW_POS];
      umode_pkg::insn_csr:    illegal_hit = in_umode && (chk_insn[29:28] != umode_pkg::MODE_U);
      default:                illegal_hit = 1'b0;
    endcase
  end

  always_comb begin
    rules = '0;
    rules[umode_pkg::rule_misa] = !chk_misa[umode_pkg::MISA_U_POS] ||
                                  chk_misa[umode_pkg::MISA_S_POS] ||
                                  chk_misa[umode_pkg::MISA_N_POS];
    rules[umode_pkg::rule_mode] = !(chk_mode inside {umode_pkg::MODE_U, umode_pkg::MODE_M});
    rules[umode_pkg::rule_mpp]  = !(mpp inside {umode_pkg::MODE_U, umode_pkg::MODE_M});
    rules[umode_pkg::rule_spp]  = chk_mstatus[umode_pkg::SPP_POS];
    rules[umode_pkg::rule_ext]  = (chk_mstatus[umode_pkg::XS_POS +: 2] != 2'b00) ||
                                  (chk_mstatus[umode_pkg::FS_POS +: 2] != 2'b00) ||
                                  chk_mstatus[umode_pkg::SD_POS];
    rules[umode_pkg::rule_mscratch] = in_umode && (chk_mscratch_wmask != '0);
    rules[umode_pkg::rule_illegal]  = illegal_hit && !traps_illegal;
    rules[umode_pkg::rule_dbg_mode] = chk_dbg_mode && (chk_mode != umode_pkg::MODE_M);
    // Rules against the previous accepted record
    rules[umode_pkg::rule_init_mode] = !seen_q && (chk_mode != umode_pkg::MODE_M);
    rules[umode_pkg::rule_trap_mode] = seen_q && prev_trap_q && (chk_mode != umode_pkg::MODE_M);
    rules[umode_pkg::rule_dret_prv]  = seen_q && prev_dbg_q && !chk_dbg_mode &&
                                       (chk_mode != prev_prv_q);
    rules[umode_pkg::rule_dbg_entry] = seen_q && !prev_dbg_q && chk_dbg_mode &&
                                       (cur_prv != prev_mode_q);
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      seen_q      <= 1'b0;
      seq_q       <= '0;
      prev_trap_q <= 1'b0;
      prev_dbg_q  <= 1'b0;
      prev_mode_q <= umode_pkg::MODE_M;
      prev_prv_q  <= umode_pkg::MODE_M;
    end else if (chk_fire) begin
      seen_q      <= 1'b1;
      seq_q       <= seq_q + 1'b1;
      prev_trap_q <= chk_trap;
      prev_dbg_q  <= chk_dbg_mode;
      prev_mode_q <= chk_mode;
      prev_prv_q  <= cur_prv;
    end
  end

  // Compliant records are consumed without touching the output register
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      push_valid <= 1'b0;
    end else if (chk_fire && (rules != '0)) begin
      push_valid <= 1'b1;
    end else if (push_fire) begin
      push_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (chk_fire && (rules != '0)) begin
      push_seq   <= seq_q;
      push_rules <= rules;
    end
  end

endmodule

`default_nettype wire

/* violation_fifo.sv */
// Output stage of the monitor, holds violation records until the consumer takes them
`timescale 1ns/1ps
`default_nettype none

module violation_fifo #(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  wire                         clk_i,
  input  wire                         rst_ni,
  input  wire                         push_valid,
  output logic                        push_ready,
  input  wire  umode_pkg::seq_t       push_seq,
  input  wire  umode_pkg::rule_mask_t push_rules,
  output logic                        viol_valid,
  input  wire                         viol_ready,
  output umode_pkg::seq_t             viol_seq,
  output umode_pkg::rule_mask_t       viol_rules
);

  localparam int unsigned PTR_W = $clog2(FIFO_DEPTH);
  localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);
  localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(FIFO_DEPTH);

  umode_pkg::seq_t       seq_mem   [FIFO_DEPTH];
  umode_pkg::rule_mask_t rules_mem [FIFO_DEPTH];
  logic [PTR_W-1:0]      wr_ptr_q;
  logic [PTR_W-1:0]      rd_ptr_q;
  logic [CNT_W-1:0]      count_q;
  logic                  push_fire;
  logic                  pop_fire;

  assign push_ready = (count_q != FULL_CNT);
  assign viol_valid = (count_q != '0);
  assign push_fire  = push_valid && push_ready;
  assign pop_fire   = viol_valid && viol_ready;

  // Head entry read straight out of the storage flops
  assign viol_seq   = seq_mem[rd_ptr_q];
  assign viol_rules = rules_mem[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (push_fire) begin
      seq_mem[wr_ptr_q]   <= push_seq;
      rules_mem[wr_ptr_q] <= push_rules;
    end
  end

  // Pointers wrap on their own since the depth is a power of two
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_fire) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_fire) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push_fire, pop_fire})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

`default_nettype wire

/* umode_monitor.sv */
// Top level of the U/M privilege compliance monitor, retire records in and violation records out
`timescale 1ns/1ps
`default_nettype none

module umode_monitor #(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  wire                         clk_i,
  input  wire                         rst_ni,
  input  wire                         rec_valid,
  output logic                        rec_ready,
  input  wire  umode_pkg::priv_mode_t rec_mode,
  input  wire  umode_pkg::insn_t      rec_insn,
  input  wire                         rec_trap,
  input  wire  umode_pkg::exc_cause_t rec_cause,
  input  wire                         rec_dbg_mode,
  input  wire  umode_pkg::csr_word_t  rec_mstatus,
  input  wire  umode_pkg::csr_word_t  rec_misa,
  input  wire  umode_pkg::csr_word_t  rec_dcsr,
  input  wire  umode_pkg::csr_word_t  rec_mscratch_wmask,
  output logic                        viol_valid,
  input  wire                         viol_ready,
  output umode_pkg::seq_t             viol_seq,
  output umode_pkg::rule_mask_t       viol_rules
);

  // Skid to checker
  wire                        chk_valid;
  wire                        chk_ready;
  wire umode_pkg::priv_mode_t chk_mode;
  wire umode_pkg::insn_t      chk_insn;
  wire                        chk_trap;
  wire umode_pkg::exc_cause_t chk_cause;
  wire                        chk_dbg_mode;
  wire umode_pkg::csr_word_t  chk_mstatus;
  wire umode_pkg::csr_word_t  chk_misa;
  wire umode_pkg::csr_word_t  chk_dcsr;
  wire umode_pkg::csr_word_t  chk_mscratch_wmask;

  // Checker to FIFO
  wire                        push_valid;
  wire                        push_ready;
  wire umode_pkg::seq_t       push_seq;
  wire umode_pkg::rule_mask_t push_rules;

  retire_skid i_skid (
    .clk_i, .rst_ni,
    .rec_valid, .rec_ready, .rec_mode, .rec_insn, .rec_trap, .rec_cause, .rec_dbg_mode,
    .rec_mstatus, .rec_misa, .rec_dcsr, .rec_mscratch_wmask,
    .chk_valid, .chk_ready, .chk_mode, .chk_insn, .chk_trap, .chk_cause, .chk_dbg_mode,
    .chk_mstatus, .chk_misa, .chk_dcsr, .chk_mscratch_wmask
  );

  priv_rule_checker i_checker (
    .clk_i, .rst_ni,
    .chk_valid, .chk_ready, .chk_mode, .chk_insn, .chk_trap, .chk_cause, .chk_dbg_mode,
    .chk_mstatus, .chk_misa, .chk_dcsr, .chk_mscratch_wmask,
    .push_valid, .push_ready, .push_seq, .push_rules
  );

  violation_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) i_fifo (
    .clk_i, .rst_ni,
    .push_valid, .push_ready, .push_seq, .push_rules,
    .viol_valid, .viol_ready, .viol_seq, .viol_rules
  );

endmodule

`default_nettype wire

/* umode_monitor_chk.sv */
// Handshake assertions on the violation output of umode_monitor, attached by bind from the testbench
`timescale 1ns/1ps
`default_nettype none

module umode_monitor_chk (
  input wire                        clk_i,
  input wire                        rst_ni,
  input wire                        viol_valid,
  input wire                        viol_ready,
  input wire umode_pkg::seq_t       viol_seq,
  input wire umode_pkg::rule_mask_t viol_rules
);

  // FIFO is empty once a reset edge has passed
  reset_empty: assert property (@(posedge clk_i) !rst_ni |=> !viol_valid)
    else $error("viol_valid is high right after a reset cycle");

  // A stalled violation keeps its contents
  stall_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (viol_valid && !viol_ready) |=> (viol_valid && $stable(viol_seq) && $stable(viol_rules)))
    else $error("violation output changed while viol_ready was low");

  // Only records with a broken rule travel out
  mask_nonzero: assert property (@(posedge clk_i) disable iff (!rst_ni)
      viol_valid |-> (viol_rules != '0))
    else $error("viol_valid is high with an empty rule mask");

endmodule

`default_nettype wire

/* tb_umode_monitor.sv */
// Testbench for umode_monitor that replays the golden records under random gating and checks violations
`timescale 1ns/1ps
`default_nettype none

module tb_umode_monitor;

  localparam int NUM_REC   = 40;
  localparam int NUM_COL   = 10;
  localparam int WAIT_MAX  = 3000;
  localparam int DRAIN_MAX = 60;

  logic                  clk_i = 1'b0;
  logic                  rst_ni = 1'b0;
  logic                  rec_valid = 1'b0;
  logic                  rec_ready;
  umode_pkg::priv_mode_t rec_mode = '0;
  umode_pkg::insn_t      rec_insn = '0;
  logic                  rec_trap = 1'b0;
  umode_pkg::exc_cause_t rec_cause = '0;
  logic                  rec_dbg_mode = 1'b0;
  umode_pkg::csr_word_t  rec_mstatus = '0;
  umode_pkg::csr_word_t  rec_misa = '0;
  umode_pkg::csr_word_t  rec_dcsr = '0;
  umode_pkg::csr_word_t  rec_mscratch_wmask = '0;
  logic                  viol_valid;
  logic                  viol_ready = 1'b0;
  umode_pkg::seq_t       viol_seq;
  umode_pkg::rule_mask_t viol_rules;

  logic [31:0] gold_mem [NUM_REC*NUM_COL];
  // Expected violations as {record index, rule mask} in golden order
  logic [27:0] exp_q [$];
  logic [31:0] lfsr = 32'hb942;
  logic        run = 1'b0;
  int          sent = 0;
  int          got = 0;

  umode_monitor i_dut (.*);

  bind umode_monitor umode_monitor_chk i_chk (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .viol_valid (viol_valid),
    .viol_ready (viol_ready),
    .viol_seq   (viol_seq),
    .viol_rules (viol_rules)
  );

  always #10 clk_i = ~clk_i;

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic load_record(input int idx);
    int base;
    base = idx * NUM_COL;
    rec_mode           <= gold_mem[base][1:0];
    rec_trap           <= gold_mem[base+1][0];
    rec_cause          <= gold_mem[base+2][5:0];
    rec_dbg_mode       <= gold_mem[base+3][0];
    rec_insn           <= gold_mem[base+4];
    rec_mstatus        <= gold_mem[base+5];
    rec_misa           <= gold_mem[base+6];
    rec_dcsr           <= gold_mem[base+7];
    rec_mscratch_wmask <= gold_mem[base+8];
  endtask

  // One LFSR step per gate bit for producer and consumer
  always @(posedge clk_i) begin : stimulus
    logic fire;
    if (run) begin
      fire = rec_valid && rec_ready;
      if (fire) begin
        sent = sent + 1;
      end
      // Fields only change once the current record is taken
      if (fire || !rec_valid) begin
        rec_valid <= 1'b0;
        if (sent < NUM_REC) begin
          lfsr = lfsr_step(lfsr);
          if (lfsr[0]) begin
            load_record(sent);
            rec_valid <= 1'b1;
          end
        end
      end
      lfsr = lfsr_step(lfsr);
      viol_ready <= lfsr[0];
    end
  end

  always @(posedge clk_i) begin : scoreboard
    if (rst_ni && viol_valid && viol_ready) begin
      assert (got < exp_q.size())
        else abort_run($sformatf("Violation for record %0d arrived when none was expected",
                                 viol_seq));
      assert ({viol_seq, viol_rules} == exp_q[got])
        else abort_run($sformatf("FAILED at time %0t: record %0d rules %03h, expected %0d %03h",
                                 $time, viol_seq, viol_rules, exp_q[got][27:12],
                                 exp_q[got][11:0]));
      got = got + 1;
    end
  end

  initial begin : main
    int waited;
    $readmemh("umode_golden.txt", gold_mem);
    for (int i = 0; i < NUM_REC; i++) begin
      if (gold_mem[i*NUM_COL+9][11:0] != 12'h000) begin
        exp_q.push_back({16'(i), gold_mem[i*NUM_COL+9][11:0]});
      end
    end
    assert (exp_q.size() > 0) else abort_run("Golden file gave no expected violations");
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;
    run    <= 1'b1;
    waited = 0;
    while (sent < NUM_REC) begin
      @(negedge clk_i);
      waited++;
      if (waited > WAIT_MAX) abort_run("Timeout while the monitor was taking the records");
    end
    waited = 0;
    while (got < exp_q.size()) begin
      @(negedge clk_i);
      waited++;
      if (waited > WAIT_MAX) abort_run("Timeout while waiting for the expected violations");
    end
    // Any extra violation shows up in the scoreboard here
    waited = 0;
    while (waited < DRAIN_MAX) begin
      @(negedge clk_i);
      waited++;
    end
    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire

/* umode_monitor.f */
umode_pkg.sv
retire_skid.sv
insn_classifier.sv
priv_rule_checker.sv
violation_fifo.sv
umode_monitor.sv
umode_monitor_chk.sv
tb_umode_monitor.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator and run it
cd "$(dirname "$0")" &&
  verilator --binary --assert -f umode_monitor.f --top-module tb_umode_monitor -o tb_umode_monitor &&
  ./obj_dir/tb_umode_monitor || exit 1

/* umode_golden.txt */
// Columns: mode trap cause dbg insn mstatus misa dcsr mscratch_wmask expected_rules
// One record per line in transfer order, the line number from 0 is the expected viol_seq
0 0 00 0 00000013 00001800 40101104 00000003 00000000 800
3 0 00 0 00000013 00001800 40101104 00000003 00000000 000
3 0 00 0 00000013 00001800 40001104 00000003 00000000 001
2 0 00 0 00000013 00001800 40101104 00000003 00000000 002
3 0 00 0 00000013 00000800 40101104 00000003 00000000 004
3 0 00 0 00000013 00001900 40101104 00000003 00000000 008
3 0 00 0 00000013 00003800 40101104 00000003 00000000 010
0 0 00 0 00000013 00001800 40101104 00000003 00000001 020
3 0 00 0 00000013 00001800 40101104 00000003 00000000 000
0 0 00 1 00000013 00001800 40101104 00000003 00000000 100
3 0 00 0 00000013 00001800 40101104 00000003 00000000 000
3 0 00 0 00200073 00001800 40101104 00000003 00000000 040
3 1 02 0 00200073 00001800 40101104 00000003 00000000 000
3 0 00 0 CC1F0073 00001800 40101104 00000003 00000000 040
0 0 00 0 30200073 00001800 40101104 00000003 00000000 040
0 1 02 0 30200073 00001800 40101104 00000003 00000000 000
3 0 00 0 00000013 00001800 40101104 00000003 00000000 000
0 0 00 0 10500073 00201800 40101104 00000003 00000000 040
0 0 00 0 10500073 00001800 40101104 00000003 00000000 000
0 0 00 0 30002573 00001800 40101104 00000003 00000000 040
0 0 00 0 C0002573 00001800 40101104 00000003 00000000 000
0 1 01 0 30200073 00001800 40101104 00000003 00000000 000
3 1 18 0 00200073 00001800 40101104 00000003 00000000 000
3 0 00 0 00000013 00001800 40101104 00000003 00000000 000
3 1 0B 0 00000073 00001800 40101104 00000003 00000000 000
0 0 00 0 00000013 00001800 40101104 00000003 00000000 080
3 0 00 0 00000013 00001800 40101104 00000003 00000000 000
3 0 00 1 00000013 00001800 40101104 00000000 00000000 400
0 0 00 0 00000013 00001800 40101104 00000003 00000000 000
3 0 00 0 00000013 00001800 40101104 00000003 00000000 000
3 0 00 1 00000013 00001800 40101104 00000003 00000000 000
0 0 00 0 00000013 00001800 40101104 00000003 00000000 200
3 0 00 0 00000013 00001800 40101104 00000003 00000000 000
0 0 00 0 10500073 00201900 40001104 00000003 FFFFFFFF 069
2 0 00 1 00000013 80000000 40101104 00000003 00000000 512
0 0 00 0 00000013 00001800 40101104 00000003 00000000 200
3 0 00 0 00000013 00001800 40101104 00000003 00000000 000
3 1 05 0 00000013 00001800 40101104 00000003 00000000 000
0 0 00 0 8C000073 00001800 40101104 00000003 0000000F 0E0
3 0 00 0 00000013 00001800 40101104 00000003 00000000 000
